// ==== depth_frame_config.svh ====
// frame size, field widths and pipeline depth for the depth write path, include where needed
`ifndef DEPTH_FRAME_CONFIG_SVH
`define DEPTH_FRAME_CONFIG_SVH

// frame size in pixels, kept small for simulation
`define FB_HRES 16
`define FB_VRES 8

// one depth cell per pixel
`define FB_DEPTH (`FB_HRES * `FB_VRES)

// ready cycles to wait after the last fragment
// covers everything still in flight toward the frame buffer
`define FLUSH_COUNT (3 * `FB_DEPTH)

// fragment depth from the rasterizer
`define Z_WIDTH 19

// stored depth, top bits of the fragment depth
`define KEY_WIDTH 12

// pixel width, taken from depth bits 16 down to 1
`define COLOR_WIDTH 16

// enough to address FB_DEPTH cells
`define ADDR_WIDTH 7

// request delay matching the depth ram read latency
`define TEST_STAGES 2

// farthest key, written by the clear pass
`define FAR_KEY {`KEY_WIDTH{1'b1}}

`endif

// ==== depth_frame_pkg.sv ====
// shared types for the depth write path, referenced by scoped name from each module
`default_nettype none

`include "depth_frame_config.svh"

package depth_frame_pkg;

  // one frame buffer / depth cell address
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // raw fragment depth
  typedef logic [`Z_WIDTH-1:0] depth_t;

  // stored depth in the ram
  typedef logic [`KEY_WIDTH-1:0] key_t;

  // pixel sent to the frame buffer
  typedef logic [`COLOR_WIDTH-1:0] color_t;

  // frame sequencer states
  typedef enum logic [1:0] {
    COUNTING,
    FLUSHING,
    CLEARING
  } frame_state_e;

  // one write toward the depth test
  // clear set means unconditional write of the far key
  typedef struct packed {
    addr_t  addr;
    depth_t depth;
    color_t color;
    logic   clear;
  } write_req_t;

endpackage

`default_nettype wire

// ==== write_req_if.sv ====
// write request bundle from the frame sequencer to the depth test, instantiated in the top level
`default_nettype none

interface write_req_if;

  // request present this cycle, no handshake
  logic valid;

  // address, depth, color and clear flag
  depth_frame_pkg::write_req_t req;

  // depth ram lookup address
  depth_frame_pkg::addr_t read_addr;

  // sequencer side
  modport source (
    output valid,
    output req,
    output read_addr
  );

  // depth test side
  modport sink (
    input valid,
    input req,
    input read_addr
  );

endinterface

`default_nettype wire

// ==== stage_delay.sv ====
// fixed-length register delay line for any payload type, used inside the depth test
`default_nettype none

module stage_delay #(
  parameter type payload_t = logic,
  parameter int  STAGES    = 2
) (
  input  wire       clk_100_passthrough,
  input  wire       sys_rst,
  input  payload_t  d,
  output payload_t  q
);

  payload_t pipe [STAGES];

  // shift one stage per clock
  // cleared on reset so a valid line starts empty
  always_ff @(posedge clk_100_passthrough) begin
    if (sys_rst) begin
      for (int i = 0; i < STAGES; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      pipe[0] <= d;
      for (int i = 1; i < STAGES; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  // oldest stage out
  assign q = pipe[STAGES-1];

endmodule

`default_nettype wire

// ==== depth_ram.sv ====
// read-first depth memory with a two-cycle registered read, used by the depth test
`default_nettype none

`include "depth_frame_config.svh"

module depth_ram (
  input  wire                            clk_100_passthrough,
  input  wire  depth_frame_pkg::addr_t   rd_addr,
  input  wire                            wr_en,
  input  wire  depth_frame_pkg::addr_t   wr_addr,
  input  wire  depth_frame_pkg::key_t    wr_key,
  output depth_frame_pkg::key_t          rd_key
);

  depth_frame_pkg::key_t mem [`FB_DEPTH];
  depth_frame_pkg::key_t rd_q;

  // zero means never written, accepted by any fragment
  initial begin
    for (int i = 0; i < `FB_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // write port
  always_ff @(posedge clk_100_passthrough) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_key;
    end
  end

  // read port, old contents on a same-address write
  // second register gives the two-cycle latency
  always_ff @(posedge clk_100_passthrough) begin
    rd_q   <= mem[rd_addr];
    rd_key <= rd_q;
  end

  // no write outside the frame
  wr_in_range: assert property (@(posedge clk_100_passthrough)
    wr_en |-> !$isunknown(wr_addr) && int'(wr_addr) < `FB_DEPTH);

endmodule

`default_nettype wire

// ==== depth_test_unit.sv ====
// depth compare and frame buffer write port, fed by the sequencer's request interface
`default_nettype none

`include "depth_frame_config.svh"

module depth_test_unit (
  write_req_if.sink                     wr,
  input  wire                           clk_100_passthrough,
  input  wire                           sys_rst,
  output logic                          fb_valid,
  output depth_frame_pkg::addr_t        fb_addr,
  output depth_frame_pkg::color_t       fb_color,
  output depth_frame_pkg::key_t         fb_key
);

  depth_frame_pkg::write_req_t req_d;
  logic                        valid_d;
  depth_frame_pkg::key_t       req_key;
  depth_frame_pkg::key_t       stored_key;
  logic                        accept;

  // request payload, lined up with the ram read
  stage_delay #(
    .payload_t (depth_frame_pkg::write_req_t),
    .STAGES    (`TEST_STAGES)
  ) req_delay (
    .clk_100_passthrough (clk_100_passthrough),
    .sys_rst             (sys_rst),
    .d                   (wr.req),
    .q                   (req_d)
  );

  // valid bit, same delay
  stage_delay #(
    .payload_t (logic),
    .STAGES    (`TEST_STAGES)
  ) valid_delay (
    .clk_100_passthrough (clk_100_passthrough),
    .sys_rst             (sys_rst),
    .d                   (wr.valid),
    .q                   (valid_d)
  );

  // accepted writes go back into the depth buffer
  depth_ram depth_ram_inst (
    .clk_100_passthrough (clk_100_passthrough),
    .rd_addr             (wr.read_addr),
    .wr_en               (accept),
    .wr_addr             (req_d.addr),
    .wr_key              (req_key),
    .rd_key              (stored_key)
  );

  // top depth bits form the key
  assign req_key = req_d.depth[`Z_WIDTH-1 -: `KEY_WIDTH];

  // nearer wins, empty cell always taken, clear always taken
  assign accept = valid_d &&
                  (req_d.clear || (req_key < stored_key) || (stored_key == '0));

  assign fb_valid = accept;
  assign fb_addr  = req_d.addr;
  assign fb_color = req_d.color;
  assign fb_key   = req_key;

  // clear request leaves as a far-key write TEST_STAGES later
  clear_is_far: assert property (@(posedge clk_100_passthrough) disable iff (sys_rst)
    (wr.valid && wr.req.clear) |-> ##(`TEST_STAGES) (fb_valid && fb_key == `FAR_KEY));

endmodule

`default_nettype wire

// ==== frame_sequencer.sv ====
// frame state machine choosing between fragment writes and the clear pass, used by the top level
`default_nettype none

`include "depth_frame_config.svh"

module frame_sequencer (
  input  wire                            clk_100_passthrough,
  input  wire                            sys_rst,
  input  wire                            frag_valid,
  input  wire  depth_frame_pkg::addr_t   frag_addr,
  input  wire  depth_frame_pkg::depth_t  frag_depth,
  input  wire                            frag_last_tri,
  input  wire                            frag_last_pixel,
  input  wire                            fb_ready,
  output logic                           frag_ready,
  output logic                           frame_sel,
  write_req_if.source                    wr
);

  localparam int FLUSH_W = $clog2(`FLUSH_COUNT);
  localparam logic [FLUSH_W-1:0] FLUSH_LAST = FLUSH_W'(`FLUSH_COUNT - 1);
  localparam depth_frame_pkg::addr_t CLEAR_LAST = `ADDR_WIDTH'(`FB_DEPTH - 1);

  depth_frame_pkg::frame_state_e state;
  logic [FLUSH_W-1:0]            flush_cnt;
  depth_frame_pkg::addr_t        clear_cnt;
  depth_frame_pkg::write_req_t   req;
  logic                          req_valid;

  // state machine and frame select
  always_ff @(posedge clk_100_passthrough) begin
    if (sys_rst) begin
      state     <= depth_frame_pkg::COUNTING;
      frame_sel <= 1'b0;
    end else begin
      case (state)
        depth_frame_pkg::COUNTING: begin
          // last pixel of last triangle, taken with fb ready
          if (frag_last_tri && frag_last_pixel && fb_ready) begin
            state <= depth_frame_pkg::FLUSHING;
          end
        end
        depth_frame_pkg::FLUSHING: begin
          if (flush_cnt == FLUSH_LAST) begin
            state     <= depth_frame_pkg::CLEARING;
            // swap to the frame just drawn
            frame_sel <= ~frame_sel;
          end
        end
        depth_frame_pkg::CLEARING: begin
          if (clear_cnt == CLEAR_LAST) begin
            state <= depth_frame_pkg::COUNTING;
          end
        end
        default: state <= depth_frame_pkg::COUNTING;
      endcase
    end
  end

  // flush wait, counts ready cycles only
  always_ff @(posedge clk_100_passthrough) begin
    if (sys_rst || state != depth_frame_pkg::FLUSHING) begin
      flush_cnt <= '0;
    end else if (fb_ready && flush_cnt != FLUSH_LAST) begin
      flush_cnt <= flush_cnt + 1'b1;
    end
  end

  // clear address, holds while the frame buffer stalls
  always_ff @(posedge clk_100_passthrough) begin
    if (sys_rst || state != depth_frame_pkg::CLEARING) begin
      clear_cnt <= '0;
    end else if (fb_ready && clear_cnt != CLEAR_LAST) begin
      clear_cnt <= clear_cnt + 1'b1;
    end
  end

  // request source by state
  always_comb begin
    if (state == depth_frame_pkg::CLEARING) begin
      req_valid   = 1'b1;
      req.addr    = clear_cnt;
      // far key in the top bits, rest don't matter
      req.depth   = {`FAR_KEY, {(`Z_WIDTH - `KEY_WIDTH){1'b0}}};
      req.color   = '0;
      req.clear   = 1'b1;
    end else begin
      // counting and flushing share the fragment path
      req_valid   = frag_valid;
      req.addr    = frag_addr;
      req.depth   = frag_depth;
      req.color   = frag_depth[`Z_WIDTH-3 -: `COLOR_WIDTH];
      req.clear   = 1'b0;
    end
  end

  assign wr.valid     = req_valid;
  assign wr.req       = req;
  // lookup at the same cell the write goes to
  assign wr.read_addr = req.addr;

  assign frag_ready = (state == depth_frame_pkg::COUNTING);

  // clear sweep stays inside the frame
  clear_in_range: assert property (@(posedge clk_100_passthrough) disable iff (sys_rst)
    state == depth_frame_pkg::CLEARING |-> int'(clear_cnt) <= `FB_DEPTH - 1);

endmodule

`default_nettype wire

// ==== depth_frame_top.sv ====
// top level of the depth-buffered write path between rasterizer and frame buffer
`default_nettype none

`include "depth_frame_config.svh"

module depth_frame_top (
  input  wire                       clk_100_passthrough,
  input  wire                       sys_rst,
  // fragment stream
  input  wire                       frag_valid,
  input  wire  [`ADDR_WIDTH-1:0]    frag_addr,
  input  wire  [`Z_WIDTH-1:0]       frag_depth,
  input  wire                       frag_last_tri,
  input  wire                       frag_last_pixel,
  output logic                      frag_ready,
  // frame buffer write side
  input  wire                       fb_ready,
  output logic                      fb_valid,
  output logic [`ADDR_WIDTH-1:0]    fb_addr,
  output logic [`COLOR_WIDTH-1:0]   fb_color,
  output logic [`KEY_WIDTH-1:0]     fb_key,
  output logic                      frame_sel
);

  // sequencer to depth test
  write_req_if wr_if ();

  frame_sequencer frame_sequencer_inst (
    .clk_100_passthrough (clk_100_passthrough),
    .sys_rst             (sys_rst),
    .frag_valid          (frag_valid),
    .frag_addr           (frag_addr),
    .frag_depth          (frag_depth),
    .frag_last_tri       (frag_last_tri),
    .frag_last_pixel     (frag_last_pixel),
    .fb_ready            (fb_ready),
    .frag_ready          (frag_ready),
    .frame_sel           (frame_sel),
    .wr                  (wr_if.source)
  );

  depth_test_unit depth_test_unit_inst (
    .wr                  (wr_if.sink),
    .clk_100_passthrough (clk_100_passthrough),
    .sys_rst             (sys_rst),
    .fb_valid            (fb_valid),
    .fb_addr             (fb_addr),
    .fb_color            (fb_color),
    .fb_key              (fb_key)
  );

endmodule

`default_nettype wire

// ==== tb_depth_frame.sv ====
// self-checking testbench for depth_frame_top, built and run through project.f and the Makefile
`default_nettype none

`include "depth_frame_config.svh"

module tb_depth_frame;

  localparam int N_FRESH   = 32;
  localparam int N_REVISIT = 48;
  localparam int N_NEXT    = 32;
  // fragment phases plus flush and clear with fb_ready high about half the time
  localparam int CYCLE_LIMIT = N_FRESH + N_REVISIT + N_NEXT + 64
                               + 4 * `FLUSH_COUNT + 4 * `FB_DEPTH;

  // one request as driven, checked two cycles later
  typedef struct packed {
    logic                   v;
    logic [`ADDR_WIDTH-1:0] a;
    logic [`Z_WIDTH-1:0]    d;
  } slot_t;

  logic                    clk_100_passthrough = 1'b0;
  logic                    sys_rst;
  logic                    frag_valid;
  logic [`ADDR_WIDTH-1:0]  frag_addr;
  logic [`Z_WIDTH-1:0]     frag_depth;
  logic                    frag_last_tri;
  logic                    frag_last_pixel;
  logic                    fb_ready;
  logic                    frag_ready;
  logic                    fb_valid;
  logic [`ADDR_WIDTH-1:0]  fb_addr;
  logic [`COLOR_WIDTH-1:0] fb_color;
  logic [`KEY_WIDTH-1:0]   fb_key;
  logic                    frame_sel;

  logic [31:0]           lfsr = 32'hfcc5_dccb;
  logic [`KEY_WIDTH-1:0] model_key [`FB_DEPTH];
  slot_t                 pending [$];
  int                    errors = 0;
  int                    checks = 0;
  int                    tests_failed = 0;
  int                    accepted;
  int                    rejected;
  int                    cycle_count = 0;

  depth_frame_top depth_frame_top_inst (.*);

  always #2 clk_100_passthrough = ~clk_100_passthrough;

  // hard stop if the DUT never finishes a phase
  always @(posedge clk_100_passthrough) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  // galois lfsr, one step per bit, bits collected msb first
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic end_test(input int num, input string name, input int err_before);
    if (errors != err_before) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "FAILED");
  endtask

  // inputs change right after the rising edge
  task automatic drive_inputs(input logic v, input logic [`ADDR_WIDTH-1:0] a,
                              input logic [`Z_WIDTH-1:0] d, input logic lt,
                              input logic lp, input logic r);
    @(posedge clk_100_passthrough);
    frag_valid      <= v;
    frag_addr       <= a;
    frag_depth      <= d;
    frag_last_tri   <= lt;
    frag_last_pixel <= lp;
    fb_ready        <= r;
  endtask

  // compare one output slot with the depth model
  task automatic check_slot(input slot_t s);
    logic [`KEY_WIDTH-1:0] key;
    logic                  exp_valid;
    key       = s.d[`Z_WIDTH-1 -: `KEY_WIDTH];
    // nearer wins, an empty cell takes anything
    exp_valid = s.v && (key < model_key[s.a] || model_key[s.a] == '0);
    checks++;
    if (fb_valid !== exp_valid) begin
      report_mismatch("fb_valid", 32'(fb_valid), 32'(exp_valid));
    end
    if (exp_valid) begin
      if (fb_addr !== s.a) begin
        report_mismatch("fb_addr", 32'(fb_addr), 32'(s.a));
      end
      if (fb_color !== s.d[16:1]) begin
        report_mismatch("fb_color", 32'(fb_color), 32'(s.d[16:1]));
      end
      if (fb_key !== key) begin
        report_mismatch("fb_key", 32'(fb_key), 32'(key));
      end
      model_key[s.a] = key;
      accepted++;
    end else if (s.v) begin
      rejected++;
    end
  endtask

  // one fragment cycle, outputs sampled mid-cycle
  task automatic step_fragment(input logic v, input logic [`ADDR_WIDTH-1:0] a,
                               input logic [`Z_WIDTH-1:0] d);
    drive_inputs(v, a, d, 1'b0, 1'b0, 1'b1);
    pending.push_back('{v: v, a: a, d: d});
    @(negedge clk_100_passthrough);
    if (pending.size() > 2) begin
      check_slot(pending.pop_front());
    end
  endtask

  initial begin
    logic [31:0]         rnd;
    logic [`Z_WIDTH-1:0] d;
    logic                r;
    logic                toggled;
    int                  base;
    int                  err_before;
    int                  ready_seen;
    int                  next_addr;
    sys_rst         <= 1'b1;
    frag_valid      <= 1'b0;
    frag_addr       <= '0;
    frag_depth      <= '0;
    frag_last_tri   <= 1'b0;
    frag_last_pixel <= 1'b0;
    fb_ready        <= 1'b0;
    for (int i = 0; i < `FB_DEPTH; i++) begin
      model_key[i] = '0;
    end
    repeat (2) @(posedge clk_100_passthrough);
    sys_rst <= 1'b0;

    // reset state
    err_before = errors;
    @(negedge clk_100_passthrough);
    if (fb_valid !== 1'b0) begin
      report_mismatch("fb_valid", 32'(fb_valid), 32'd0);
    end
    if (frag_ready !== 1'b1) begin
      report_mismatch("frag_ready", 32'(frag_ready), 32'd1);
    end
    if (frame_sel !== 1'b0) begin
      report_mismatch("frame_sel", 32'(frame_sel), 32'd0);
    end
    end_test(1, "reset state", err_before);

    // odd stride keeps every address distinct
    err_before = errors;
    accepted   = 0;
    rnd        = take_bits(`ADDR_WIDTH);
    base       = int'(rnd[`ADDR_WIDTH-1:0]);
    for (int i = 0; i < N_FRESH; i++) begin
      rnd = take_bits(`Z_WIDTH);
      step_fragment(1'b1, `ADDR_WIDTH'(base + i * 37), rnd[`Z_WIDTH-1:0]);
    end
    repeat (2) step_fragment(1'b0, '0, '0);
    end_test(2, $sformatf("fresh cells, %0d written", accepted), err_before);

    // four cells in rotation, each one revisited every fourth cycle
    err_before = errors;
    accepted   = 0;
    rejected   = 0;
    for (int i = 0; i < N_REVISIT; i++) begin
      rnd = take_bits(`Z_WIDTH);
      step_fragment(1'b1, `ADDR_WIDTH'(base + (i % 4) * 37), rnd[`Z_WIDTH-1:0]);
    end
    repeat (2) step_fragment(1'b0, '0, '0);
    end_test(3, $sformatf("revisits, %0d nearer %0d hidden", accepted, rejected),
             err_before);

    // only idle slots left in the queue
    pending.delete();
    err_before = errors;
    ready_seen = 0;
    toggled    = 1'b0;
    drive_inputs(1'b0, '0, '0, 1'b1, 1'b1, 1'b1);
    @(negedge clk_100_passthrough);
    while (!toggled) begin
      rnd = take_bits(1);
      r   = rnd[0];
      drive_inputs(1'b0, '0, '0, 1'b0, 1'b0, r);
      @(negedge clk_100_passthrough);
      if (frame_sel !== 1'b0) begin
        toggled = 1'b1;
        if (ready_seen < `FLUSH_COUNT - 1) begin
          report_failure($sformatf("frame_sel toggled after only %0d ready cycles",
                                   ready_seen));
        end
      end else begin
        if (frag_ready !== 1'b0) begin
          report_mismatch("frag_ready", 32'(frag_ready), 32'd0);
        end
        if (fb_valid !== 1'b0) begin
          report_mismatch("fb_valid", 32'(fb_valid), 32'd0);
        end
      end
      if (r) begin
        ready_seen++;
      end
    end
    end_test(4, $sformatf("flush, %0d ready cycles", ready_seen), err_before);

    // clear sweep, a stalled address may show up twice
    err_before = errors;
    next_addr  = 0;
    while (next_addr < `FB_DEPTH) begin
      rnd = take_bits(1);
      drive_inputs(1'b0, '0, '0, 1'b0, 1'b0, rnd[0]);
      @(negedge clk_100_passthrough);
      if (fb_valid === 1'b1) begin
        if (fb_color !== '0) begin
          report_mismatch("fb_color", 32'(fb_color), 32'd0);
        end
        if (fb_key !== `FAR_KEY) begin
          report_mismatch("fb_key", 32'(fb_key), 32'(`FAR_KEY));
        end
        if (int'(fb_addr) == next_addr) begin
          next_addr++;
        end else if (!(next_addr > 0 && int'(fb_addr) == next_addr - 1)) begin
          report_failure($sformatf("clear wrote address %0d while %0d was due",
                                   fb_addr, next_addr));
          next_addr++;
        end
      end else if (next_addr > 0) begin
        report_failure($sformatf("clear sweep paused before address %0d", next_addr));
      end
    end
    if (frag_ready !== 1'b1) begin
      report_mismatch("frag_ready", 32'(frag_ready), 32'd1);
    end
    for (int i = 0; i < `FB_DEPTH; i++) begin
      model_key[i] = `FAR_KEY;
    end
    end_test(5, "clear sweep", err_before);

    // about half the fragments carry the far key and must be dropped
    err_before = errors;
    accepted   = 0;
    rejected   = 0;
    rnd        = take_bits(`ADDR_WIDTH);
    base       = int'(rnd[`ADDR_WIDTH-1:0]);
    for (int i = 0; i < N_NEXT; i++) begin
      rnd = take_bits(`Z_WIDTH);
      d   = rnd[`Z_WIDTH-1:0];
      rnd = take_bits(1);
      if (rnd[0]) begin
        d[`Z_WIDTH-1 -: `KEY_WIDTH] = `FAR_KEY;
      end
      step_fragment(1'b1, `ADDR_WIDTH'(base + i * 37), d);
    end
    repeat (2) step_fragment(1'b0, '0, '0);
    end_test(6, $sformatf("next frame, %0d written %0d far", accepted, rejected),
             err_before);

    $display("6 tests, %0d failed, %0d slot checks, %0d errors",
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
depth_frame_pkg.sv
write_req_if.sv
stage_delay.sv
depth_ram.sv
depth_test_unit.sv
frame_sequencer.sv
depth_frame_top.sv
tb_depth_frame.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_depth_frame
RTL_TOP   ?= depth_frame_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

# pass only when the testbench printed the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
